// File: dv/boothMultiplierTb.sv
`timescale 1ns/1ps

module boothMultiplierTb;
    import mulPkg::*;

    // isolated requests right after reset
    localparam int SingleCount = 8;
    // random requests per operation
    localparam int RandomPerOp = 50;
    // mixed back-to-back burst
    localparam int MixedCount = 100;
    // corner value table size, every pair for every op
    localparam int CornerCount = 5;
    localparam int TotalRequests = SingleCount + 3 * RandomPerOp + MixedCount
                                 + 3 * CornerCount * CornerCount;
    localparam int TimeoutCycles = TotalRequests * 4 + 100;

    // expected result and destination for one request
    typedef struct packed {
        logic [31:0] value;
        archRegT     dest;
    } expectT;

    logic           Clk;
    logic           reset;
    logic           mulStart;
    mulOpT          mulOp;
    logic [31:0]    multiplicand;
    logic [31:0]    multiplier;
    archRegT        destReg;
    logic [31:0]    product;
    archRegT        productDest;
    logic           productValid;

    // scoreboard, filled at the strobe and read in order
    expectT         expected [TotalRequests];
    int             writeIndex = 0;
    int             readIndex = 0;
    logic [31:0]    headValue;
    archRegT        headDest;
    int             cycleCount = 0;
    logic [31:0]    lfsrState = 32'h264c_27a4;

    boothMultiplier boothMultiplier_inst (
        .Clk          (Clk),
        .reset        (reset),
        .mulStart     (mulStart),
        .mulOp        (mulOp),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .destReg      (destReg),
        .product      (product),
        .productDest  (productDest),
        .productValid (productValid)
    );

    // 8 ns clock
    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // one lfsr step per bit, bits land at the bottom
    task automatic takeBits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
    endtask

    // full 64-bit product from extended operands, then pick the half
    function automatic logic [31:0] modelResult(
        input mulOpT       op,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [63:0] aWide;
        logic [63:0] bWide;
        logic [63:0] full;
        if (op == mulhWu) begin
            aWide = {32'b0, a};
            bWide = {32'b0, b};
        end else begin
            aWide = {{32{a[31]}}, a};
            bWide = {{32{b[31]}}, b};
        end
        full = aWide * bWide;
        return (op == mulW) ? full[31:0] : full[63:32];
    endfunction

    function automatic logic [31:0] cornerValue(input int index);
        case (index)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    function automatic mulOpT opFromIndex(input int index);
        case (index)
            0:       return mulW;
            1:       return mulhW;
            default: return mulhWu;
        endcase
    endfunction

    // one strobe, expected entry goes in on the same edge
    task automatic issueRequest(
        input mulOpT       op,
        input logic [31:0] a,
        input logic [31:0] b,
        input archRegT     dest
    );
        expectT entry;
        entry.value = modelResult(op, a, b);
        entry.dest = dest;
        @(posedge Clk);
        mulStart <= 1'b1;
        mulOp <= op;
        multiplicand <= a;
        multiplier <= b;
        destReg <= dest;
        expected[writeIndex] <= entry;
        writeIndex <= writeIndex + 1;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge Clk);
            mulStart <= 1'b0;
        end
    endtask

    // op code 3 is not defined, draw again
    task automatic randomOp(output mulOpT op);
        logic [31:0] bits;
        do begin
            takeBits(2, bits);
        end while (bits[1:0] == 2'b11);
        op = opFromIndex(int'(bits[1:0]));
    endtask

    task automatic randomRequest(input mulOpT op, input logic forceTop);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        takeBits(32, a);
        takeBits(32, b);
        takeBits(5, d);
        // top bit set, signed and unsigned high words differ
        if (forceTop) begin
            a[31] = 1'b1;
        end
        issueRequest(op, a, b, archRegT'(d[4:0]));
    endtask

    // random gaps mix single and back-to-back strobes
    task automatic runOpBatch(input mulOpT op);
        logic [31:0] gap;
        for (int i = 0; i < RandomPerOp; i++) begin
            randomRequest(op, (op == mulhWu) && i[0]);
            takeBits(1, gap);
            if (gap[0]) begin
                idleCycles(1);
            end
        end
    endtask

    // head of the scoreboard
    always_comb begin
        headValue = 'x;
        headDest = 'x;
        if (readIndex < TotalRequests) begin
            headValue = expected[readIndex].value;
            headDest = expected[readIndex].dest;
        end
    end

    always @(posedge Clk) begin
        if (productValid) begin
            readIndex <= readIndex + 1;
        end
    end

    // run length limit
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            reportFailure($sformatf("timeout after %0d cycles, %0d of %0d results seen",
                                    cycleCount, readIndex, writeIndex));
        end
    end

    // exactly one pulse, two cycles after each strobe
    timingCheck: assert property (
        @(posedge Clk) disable iff (reset)
        productValid == $past(mulStart, 2)
    ) else reportFailure("productValid did not follow mulStart by two cycles");

    valueCheck: assert property (
        @(posedge Clk) disable iff (reset)
        productValid |-> product == headValue
    ) else reportFailure($sformatf("mismatch at %0t: product expected %h actual %h",
                                   $time, $sampled(headValue), $sampled(product)));

    destCheck: assert property (
        @(posedge Clk) disable iff (reset)
        productValid |-> productDest == headDest
    ) else reportFailure($sformatf("mismatch at %0t: productDest expected %0d actual %0d",
                                   $time, $sampled(headDest), $sampled(productDest)));

    initial begin
        mulOpT op;
        reset = 1'b1;
        mulStart = 1'b0;
        mulOp = mulW;
        multiplicand = '0;
        multiplier = '0;
        destReg = '0;
        repeat (4) @(posedge Clk);
        reset <= 1'b0;
        // quiet after reset, then isolated strobes
        idleCycles(10);
        for (int i = 0; i < SingleCount; i++) begin
            randomOp(op);
            randomRequest(op, 1'b0);
            idleCycles(3);
        end
        // one batch per op
        runOpBatch(mulW);
        runOpBatch(mulhW);
        runOpBatch(mulhWu);
        idleCycles(4);
        // mixed ops on every cycle
        for (int i = 0; i < MixedCount; i++) begin
            randomOp(op);
            randomRequest(op, 1'b0);
        end
        idleCycles(4);
        // every corner pair, including most negative squared
        for (int o = 0; o < 3; o++) begin
            for (int a = 0; a < CornerCount; a++) begin
                for (int b = 0; b < CornerCount; b++) begin
                    issueRequest(opFromIndex(o), cornerValue(a), cornerValue(b),
                                 archRegT'(a * CornerCount + b));
                end
            end
        end
        idleCycles(1);
        // drain, then a few quiet cycles for stray pulses
        while (readIndex != writeIndex) begin
            @(posedge Clk);
        end
        idleCycles(5);
        if (readIndex == TotalRequests && writeIndex == TotalRequests) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            reportFailure($sformatf("request count wrong, %0d issued, %0d returned",
                                    writeIndex, readIndex));
        end
    end

endmodule

// File: hdl/boothEncoder.sv
`timescale 1ns/1ps

module boothEncoder #(
    parameter int OperandWidth = 32
) (
    input  logic                                                Clk,
    input  logic                                                reset,
    input  logic                                                mulStart,
    input  mulPkg::mulOpT                                       mulOp,
    input  logic [OperandWidth-1:0]                             multiplicand,
    input  logic [OperandWidth-1:0]                             multiplier,
    input  mulPkg::archRegT                                     destReg,
    output logic                                                stageValid,
    output mulPkg::mulTagT                                      stageTag,
    output logic [(OperandWidth+2)/2-1:0][2*OperandWidth+1:0]   partialRows,
    output logic [2*OperandWidth+1:0]                           negateBits
);
    import mulPkg::*;

    // operands grow by two bits so mulhWu stays positive
    localparam int ExtWidth = OperandWidth + 2;
    localparam int RowWidth = 2 * OperandWidth + 2;
    localparam int NumDigits = ExtWidth / 2;

    typedef logic [RowWidth-1:0] rowT;

    logic                   signedOp;
    logic [ExtWidth-1:0]    mcandExt;
    logic [ExtWidth-1:0]    mplierExt;
    // multiplier with the implied zero below bit 0
    logic [ExtWidth:0]      mplierPadded;
    rowT                    mcandOnce;
    rowT                    mcandTwice;
    rowT [NumDigits-1:0]    rowsNext;
    rowT                    negateNext;

    // one row from a three-bit group
    // negative digits come out inverted, the +1 is added elsewhere
    function automatic rowT boothRow(
        input logic [2:0] group,
        input rowT        once,
        input rowT        twice
    );
        case (group)
            3'b001, 3'b010: boothRow = once;
            3'b011:         boothRow = twice;
            3'b100:         boothRow = ~twice;
            3'b101, 3'b110: boothRow = ~once;
            // 000 and 111 are both a zero digit
            default:        boothRow = '0;
        endcase
    endfunction

    // sign extension for the signed ops, zero extension for mulhWu
    assign signedOp = (mulOp != mulhWu);
    assign mcandExt = {{2{signedOp & multiplicand[OperandWidth-1]}}, multiplicand};
    assign mplierExt = {{2{signedOp & multiplier[OperandWidth-1]}}, multiplier};
    assign mplierPadded = {mplierExt, 1'b0};

    // multiplicand spread over the full row width
    assign mcandOnce = {{(RowWidth-ExtWidth){mcandExt[ExtWidth-1]}}, mcandExt};
    assign mcandTwice = mcandOnce << 1;

    for (genvar d = 0; d < NumDigits; d++) begin : genDigit
        logic [2:0] group;
        logic       negDigit;

        // overlapping window, bits 2d+1 .. 2d-1
        assign group = mplierPadded[2*d +: 3];
        // 111 is minus zero, no correction
        assign negDigit = group[2] & ~(group[1] & group[0]);
        assign rowsNext[d] = boothRow(group, mcandOnce, mcandTwice) << (2 * d);
        // two's complement +1 at this digit's weight
        assign negateNext[2*d] = negDigit;
        assign negateNext[2*d+1] = 1'b0;
    end

    // above the last digit weight no correction bits
    assign negateNext[RowWidth-1:ExtWidth] = '0;

    // pipeline valid
    always_ff @(posedge Clk) begin
        if (reset) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= mulStart;
        end
    end

    // payload only moves on a request
    always_ff @(posedge Clk) begin
        if (mulStart) begin
            partialRows <= rowsNext;
            negateBits <= negateNext;
            stageTag.op <= mulOp;
            stageTag.destReg <= destReg;
        end
    end

    // the caller must never issue the unused op code
    opDefinedCheck: assert property (
        @(posedge Clk) disable iff (reset)
        mulStart |-> mulOp inside {mulW, mulhW, mulhWu}
    ) else $error("boothEncoder: undefined mulOp %0d at request", mulOp);

endmodule

// File: hdl/boothMultiplier.sv
`timescale 1ns/1ps

module boothMultiplier #(
    parameter int OperandWidth = 32
) (
    input  logic                        Clk,
    input  logic                        reset,
    input  logic                        mulStart,
    input  mulPkg::mulOpT               mulOp,
    input  logic [OperandWidth-1:0]     multiplicand,
    input  logic [OperandWidth-1:0]     multiplier,
    input  mulPkg::archRegT             destReg,
    output logic [OperandWidth-1:0]     product,
    output mulPkg::archRegT             productDest,
    output logic                        productValid
);
    import mulPkg::*;

    localparam int RowWidth = 2 * OperandWidth + 2;
    localparam int NumDigits = (OperandWidth + 2) / 2;

    // stage 1 to tree and stage 2
    logic                               stageValid;
    mulTagT                             stageTag;
    logic [NumDigits-1:0][RowWidth-1:0] partialRows;
    logic [RowWidth-1:0]                negateBits;
    // tree to stage 2
    logic [RowWidth-1:0]                sumRow;
    logic [RowWidth-1:0]                carryRow;

    // booth recoding, registered
    boothEncoder #(
        .OperandWidth (OperandWidth)
    ) boothEncoder_inst (
        .Clk          (Clk),
        .reset        (reset),
        .mulStart     (mulStart),
        .mulOp        (mulOp),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .destReg      (destReg),
        .stageValid   (stageValid),
        .stageTag     (stageTag),
        .partialRows  (partialRows),
        .negateBits   (negateBits)
    );

    // combinational reduction down to two rows
    wallaceTree #(
        .OperandWidth (OperandWidth)
    ) wallaceTree_inst (
        .partialRows  (partialRows),
        .negateBits   (negateBits),
        .sumRow       (sumRow),
        .carryRow     (carryRow)
    );

    // final add and half select, registered
    productStage #(
        .OperandWidth (OperandWidth)
    ) productStage_inst (
        .Clk          (Clk),
        .reset        (reset),
        .stageValid   (stageValid),
        .stageTag     (stageTag),
        .sumRow       (sumRow),
        .carryRow     (carryRow),
        .product      (product),
        .productDest  (productDest),
        .productValid (productValid)
    );

endmodule

// File: hdl/mulPkg.sv
package mulPkg;

    // operation selector for the multiply unit
    // all three ops form the full double-width product
    // and differ only in the extension and the half returned
    typedef enum logic [1:0] {
        // low word, sign does not matter
        mulW   = 2'b00,
        // high word, both operands signed
        mulhW  = 2'b01,
        // high word, both operands unsigned
        mulhWu = 2'b10
    } mulOpT;

    // architectural register file address
    typedef logic [4:0] archRegT;

    // sideband carried next to the partial products
    // op picks the result half in the last stage
    // destReg goes back out with the result
    typedef struct packed {
        mulOpT   op;
        archRegT destReg;
    } mulTagT;

endpackage

// File: hdl/productStage.sv
`timescale 1ns/1ps

module productStage #(
    parameter int OperandWidth = 32
) (
    input  logic                        Clk,
    input  logic                        reset,
    input  logic                        stageValid,
    input  mulPkg::mulTagT              stageTag,
    input  logic [2*OperandWidth+1:0]   sumRow,
    input  logic [2*OperandWidth+1:0]   carryRow,
    output logic [OperandWidth-1:0]     product,
    output mulPkg::archRegT             productDest,
    output logic                        productValid
);
    import mulPkg::*;

    localparam int RowWidth = 2 * OperandWidth + 2;

    typedef logic [OperandWidth-1:0] wordT;

    // only the low double width is meaningful
    logic [RowWidth-1:0]    fullSum;
    wordT                   resultWord;

    // final carry-propagate add
    assign fullSum = sumRow + carryRow;

    // mulW takes the low word and the high variants the high word
    assign resultWord = (stageTag.op == mulW) ? fullSum[OperandWidth-1:0]
                                              : fullSum[2*OperandWidth-1:OperandWidth];

    // one valid pulse per request
    always_ff @(posedge Clk) begin
        if (reset) begin
            productValid <= 1'b0;
        end else begin
            productValid <= stageValid;
        end
    end

    // result payload
    always_ff @(posedge Clk) begin
        if (stageValid) begin
            product <= resultWord;
            productDest <= stageTag.destReg;
        end
    end

    // the two extension bits only repeat the product sign
    // and stay zero for mulhWu
    extensionCheck: assert property (
        @(posedge Clk) disable iff (reset)
        stageValid |-> fullSum[RowWidth-1:2*OperandWidth]
                       == {2{(stageTag.op != mulhWu) && fullSum[2*OperandWidth-1]}}
    ) else $error("productStage: bits above the product are not a sign extension");

endmodule

// File: hdl/wallaceTree.sv
`timescale 1ns/1ps

module wallaceTree #(
    parameter int OperandWidth = 32
) (
    input  logic [(OperandWidth+2)/2-1:0][2*OperandWidth+1:0]   partialRows,
    input  logic [2*OperandWidth+1:0]                           negateBits,
    output logic [2*OperandWidth+1:0]                           sumRow,
    output logic [2*OperandWidth+1:0]                           carryRow
);

    localparam int RowWidth = 2 * OperandWidth + 2;
    localparam int NumDigits = (OperandWidth + 2) / 2;
    // booth rows plus the row of negate bits
    localparam int NumAddends = NumDigits + 1;

    typedef logic [RowWidth-1:0] rowT;

    // one 3:2 compressor output, carry already moved up one bit
    typedef struct packed {
        rowT sum;
        rowT carry;
    } csaOutT;

    // rows left after one level of 3:2 compression
    function automatic int rowsAfter(input int rows);
        return (rows / 3) * 2 + rows % 3;
    endfunction

    // rows entering a given level
    function automatic int rowsAtLevel(input int level);
        int rows;
        rows = NumAddends;
        for (int l = 0; l < level; l++) begin
            rows = rowsAfter(rows);
        end
        return rows;
    endfunction

    // levels until two rows remain, six for 32-bit operands
    function automatic int levelCount();
        int rows;
        int levels;
        rows = NumAddends;
        levels = 0;
        while (rows > 2) begin
            rows = rowsAfter(rows);
            levels++;
        end
        return levels;
    endfunction

    localparam int NumLevels = levelCount();

    // bitwise full adder over whole rows
    function automatic csaOutT fullAdd(
        input rowT a,
        input rowT b,
        input rowT c
    );
        csaOutT result;
        result.sum = a ^ b ^ c;
        // top carry falls off, sums are modulo the row width
        result.carry = ((a & b) | (b & c) | (a & c)) << 1;
        return result;
    endfunction

    // rows at every level, level 0 is the input set
    rowT [NumLevels:0][NumAddends-1:0] levelRows;
    rowT                               addendTotal;

    // negate bits ride as the last addend
    assign levelRows[0] = {negateBits, partialRows};

    for (genvar lvl = 0; lvl < NumLevels; lvl++) begin : genLevel
        localparam int RowsIn = rowsAtLevel(lvl);
        localparam int Groups = RowsIn / 3;
        localparam int RowsOut = rowsAfter(RowsIn);

        // full groups of three
        for (genvar g = 0; g < Groups; g++) begin : genCsa
            csaOutT csaOut;

            assign csaOut = fullAdd(levelRows[lvl][3*g],
                                    levelRows[lvl][3*g+1],
                                    levelRows[lvl][3*g+2]);
            assign levelRows[lvl+1][2*g] = csaOut.sum;
            assign levelRows[lvl+1][2*g+1] = csaOut.carry;
        end

        // one or two leftover rows skip this level
        for (genvar k = 3 * Groups; k < RowsIn; k++) begin : genPass
            assign levelRows[lvl+1][k-Groups] = levelRows[lvl][k];
        end

        // slots no longer in use
        for (genvar r = RowsOut; r < NumAddends; r++) begin : genIdle
            assign levelRows[lvl+1][r] = '0;
        end
    end

    assign sumRow = levelRows[NumLevels][0];
    assign carryRow = levelRows[NumLevels][1];

    // plain sum of all addends for comparison
    always_comb begin
        addendTotal = '0;
        for (int i = 0; i < NumAddends; i++) begin
            addendTotal = addendTotal + levelRows[0][i];
        end
    end

    // tree output must still add up to the input total
    always_comb begin
        if (!$isunknown(addendTotal)) begin
            sumCheck: assert (rowT'(sumRow + carryRow) == addendTotal)
                else $error("wallaceTree: rows sum to %h, addends to %h",
                            rowT'(sumRow + carryRow), addendTotal);
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the multiplier testbench with Verilator.
# Exit status is zero only when the pass message is printed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module boothMultiplierTb \
    -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/VboothMultiplierTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// File: sources.f
hdl/mulPkg.sv
hdl/boothEncoder.sv
hdl/wallaceTree.sv
hdl/productStage.sv
hdl/boothMultiplier.sv
dv/boothMultiplierTb.sv
